/* mcoi_motor_link.f */
src/mcoi_motor_pkg.sv
src/mcoi_link_pkg.sv
src/interlock_gate.sv
src/motor_channel.sv
src/status_page_mux.sv
src/mcoi_motor_link.sv
sim/tb_mcoi_motor_link.sv

/* run_sim.sh */
#!/bin/sh
# build and run the motor link testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f mcoi_motor_link.f \
   --top-module tb_mcoi_motor_link \
   -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Regression failed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"

/* sim/tb_mcoi_motor_link.sv */
//--------------------------------------------------------------------------
// testbench for the motor link core: a table of link frames, feedback
// words, pin inputs and page selectors, checked against expected values
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ns

module tb_mcoi_motor_link;

   // polls of 10 ns before a missing clock edge counts as a timeout
   localparam int POLL_LIMIT = 40;

   typedef struct {
      logic [31:0] fb;
      logic [63:0] cmd;
      logic [15:0] pfail_n;
      logic [15:0] sw_a_n;
      logic [15:0] sw_b_n;
      logic        rs485;
      logic [31:0] page_sel;
      logic        page_new;
      logic        clken;
      int          settle;
   } row_t;

   logic        clk;
   logic        arst_n;
   logic [63:0] rx_motor_data;
   logic        rx_clken;
   logic [31:0] feedback;
   logic [31:0] page_sel;
   logic        page_new;
   logic [3:0]  pcb_rev;
   logic        rs485_ro;
   logic [15:0] pfail_n;
   logic [15:0] sw_a_n;
   logic [15:0] sw_b_n;
   logic [15:0] pl_clk;
   logic [15:0] pl_en;
   logic [15:0] pl_dir;
   logic [15:0] pl_boost;
   logic [63:0] tx_motor_data;
   logic [31:0] page_data;
   logic        rs485_di;
   logic        link_led_n;

   row_t        rows[$];
   int          err_count;
   logic        timed_out;
   // model state of the loopback register and the readout word
   logic [31:0] exp_loop;
   logic [31:0] exp_page;

   mcoi_motor_link i_dut (
      .gbt_rx_clkrs    (clk),
      .arst_n_i        (arst_n),
      .rx_motor_data_i (rx_motor_data),
      .rx_clken_i      (rx_clken),
      .feedback_i      (feedback),
      .page_sel_i      (page_sel),
      .page_new_i      (page_new),
      .pcb_rev_i       (pcb_rev),
      .rs485_ro_i      (rs485_ro),
      .pfail_n_i       (pfail_n),
      .sw_a_n_i        (sw_a_n),
      .sw_b_n_i        (sw_b_n),
      .pl_clk_o        (pl_clk),
      .pl_en_o         (pl_en),
      .pl_dir_o        (pl_dir),
      .pl_boost_o      (pl_boost),
      .tx_motor_data_o (tx_motor_data),
      .page_data_o     (page_data),
      .rs485_di_o      (rs485_di),
      .link_led_n_o    (link_led_n)
   );

   // 100 ns link clock
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //-----------------------------------------------------------------------
   // helpers
   //-----------------------------------------------------------------------
   // returns 5 ns after each rising edge, the poll grid never meets an edge
   task automatic wait_edges(input int n);
      int polls;
      for (int i = 0; i < n && !timed_out; i++) begin
         polls = 0;
         while (clk !== 1'b0 && polls < POLL_LIMIT) begin
            #10;
            polls++;
         end
         while (clk !== 1'b1 && polls < POLL_LIMIT) begin
            #10;
            polls++;
         end
         if (polls >= POLL_LIMIT) begin
            $display("timeout: no rising clock edge seen within %0d ns", POLL_LIMIT * 10);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         err_count++;
      end
   endtask

   function automatic logic [31:0] random_sel(input logic [7:0] page);
      return {24'($urandom()), page};
   endfunction

   task automatic random_pins(output logic [15:0] pf, output logic [15:0] sa,
                              output logic [15:0] sb);
      pf = 16'($urandom());
      sa = 16'($urandom());
      sb = 16'($urandom());
   endtask

   task automatic add_row(input logic [31:0] fb, input logic [63:0] cmd,
                          input logic [15:0] pf, input logic [15:0] sa,
                          input logic [15:0] sb, input logic [31:0] sel,
                          input logic pnew, input logic ce, input int settle,
                          input logic rs = 1'b0);
      row_t r;
      r.fb       = fb;
      r.cmd      = cmd;
      r.pfail_n  = pf;
      r.sw_a_n   = sa;
      r.sw_b_n   = sb;
      r.rs485    = rs;
      r.page_sel = sel;
      r.page_new = pnew;
      r.clken    = ce;
      r.settle   = settle;
      rows.push_back(r);
   endtask

   // readout word as the page map defines it
   function automatic logic [31:0] expected_page(input logic [7:0] page,
                                                 input logic [63:0] stat);
      logic [31:0] w;
      int          idx;
      idx = int'(page) - int'(mcoi_link_pkg::PAGE_MOTOR_BASE);
      case (page)
         mcoi_link_pkg::PAGE_LOOPBACK: w = exp_loop;
         mcoi_link_pkg::PAGE_BUILD:    w = mcoi_link_pkg::BUILD_ID;
         mcoi_link_pkg::PAGE_PCBREV:   w = {28'b0, pcb_rev};
         mcoi_link_pkg::PAGE_ONE:      w = 32'd1;
         mcoi_link_pkg::PAGE_RS485:    w = {31'b0, rs485_ro};
         default: begin
            if (idx >= 0 && idx < 16) begin
               w = {28'b0, stat[idx*4 +: 4]};
            end else begin
               w = mcoi_link_pkg::POISON_WORD;
            end
         end
      endcase
      return w;
   endfunction

   //-----------------------------------------------------------------------
   // stimulus table
   //-----------------------------------------------------------------------
   task automatic build_table();
      logic [31:0] key;
      logic [15:0] pf;
      logic [15:0] sa;
      logic [15:0] sb;
      key = mcoi_link_pkg::INTERLOCK_KEY;
      random_pins(pf, sa, sb);
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(mcoi_link_pkg::PAGE_BUILD), 1'b0, 1'b1, 4);
      random_pins(pf, sa, sb);
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(mcoi_link_pkg::PAGE_PCBREV), 1'b0, 1'b1, 4);
      // broken interlock, then one cycle latency both ways with pins held
      random_pins(pf, sa, sb);
      add_row(key ^ 32'h1, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(mcoi_link_pkg::PAGE_ONE), 1'b0, 1'b1, 4);
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(mcoi_link_pkg::PAGE_ONE), 1'b0, 1'b0, 1);
      add_row(key ^ 32'h100, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(mcoi_link_pkg::PAGE_ONE), 1'b0, 1'b0, 1);
      // one status page per motor
      for (int m = 0; m < mcoi_motor_pkg::NUM_MOTORS; m++) begin
         random_pins(pf, sa, sb);
         add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
                 random_sel(mcoi_link_pkg::PAGE_MOTOR_BASE + 8'(m)), 1'b0, 1'b1, 4);
      end
      // rs-485 receive line read high, then low
      random_pins(pf, sa, sb);
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(mcoi_link_pkg::PAGE_RS485), 1'b0, 1'b1, 4, 1'b1);
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(mcoi_link_pkg::PAGE_RS485), 1'b0, 1'b1, 4, 1'b0);
      // pages outside the map
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb, random_sel(8'd5), 1'b0, 1'b1, 4);
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb, random_sel(8'd40), 1'b0, 1'b1, 4);
      // loopback reload with and without the maintenance bit
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
              {1'b1, 23'($urandom()), mcoi_link_pkg::PAGE_LOOPBACK}, 1'b1, 1'b1, 4);
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
              {1'b0, 23'($urandom()), mcoi_link_pkg::PAGE_LOOPBACK}, 1'b1, 1'b1, 4);
      // readout holds while the clock enable is low
      random_pins(pf, sa, sb);
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(mcoi_link_pkg::PAGE_BUILD), 1'b0, 1'b0, 4);
      add_row(key ^ 32'hffff, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(8'd40), 1'b0, 1'b0, 4);
      add_row(key, {$urandom(), $urandom()}, pf, sa, sb,
              random_sel(mcoi_link_pkg::PAGE_LOOPBACK), 1'b0, 1'b1, 4);
   endtask

   //-----------------------------------------------------------------------
   // apply one row and compare
   //-----------------------------------------------------------------------
   task automatic apply_row(input row_t r);
      logic        match;
      logic [15:0] exp_clk;
      logic [15:0] exp_en;
      logic [15:0] exp_dir;
      logic [15:0] exp_boost;
      logic [63:0] exp_stat;
      rx_motor_data = r.cmd;
      feedback      = r.fb;
      pfail_n       = r.pfail_n;
      sw_a_n        = r.sw_a_n;
      sw_b_n        = r.sw_b_n;
      rs485_ro      = r.rs485;
      page_sel      = r.page_sel;
      page_new      = r.page_new;
      rx_clken      = r.clken;
      // page_new is a one cycle strobe
      wait_edges(1);
      page_new = 1'b0;
      wait_edges(r.settle - 1);
      match = (r.fb == mcoi_link_pkg::INTERLOCK_KEY);
      exp_stat = '0;
      for (int n = 0; n < mcoi_motor_pkg::NUM_MOTORS; n++) begin
         // parked motors see all command bits high
         exp_clk[n]   = match ? r.cmd[n*4 + mcoi_motor_pkg::CMD_STEP]  : 1'b1;
         exp_en[n]    = match ? r.cmd[n*4 + mcoi_motor_pkg::CMD_DEACT] : 1'b1;
         exp_dir[n]   = match ? r.cmd[n*4 + mcoi_motor_pkg::CMD_DIR]   : 1'b1;
         exp_boost[n] = match ? r.cmd[n*4 + mcoi_motor_pkg::CMD_BOOST] : 1'b1;
         exp_stat[n*4 + mcoi_motor_pkg::ST_FAIL] = !r.pfail_n[n];
         exp_stat[n*4 + mcoi_motor_pkg::ST_SW_A] = !r.sw_a_n[n];
         exp_stat[n*4 + mcoi_motor_pkg::ST_SW_B] = !r.sw_b_n[n];
      end
      if (r.page_new) begin
         exp_loop = {r.page_sel[31], 30'b0, 1'b1};
      end
      if (r.clken) begin
         exp_page = expected_page(r.page_sel[7:0], exp_stat);
      end
      if (!timed_out) begin
         check_value("pl_clk_o", 64'(pl_clk), 64'(exp_clk));
         check_value("pl_en_o", 64'(pl_en), 64'(exp_en));
         check_value("pl_dir_o", 64'(pl_dir), 64'(exp_dir));
         check_value("pl_boost_o", 64'(pl_boost), 64'(exp_boost));
         check_value("link_led_n_o", 64'(link_led_n), 64'(!(match && !r.page_sel[31])));
         check_value("tx_motor_data_o", tx_motor_data, exp_stat);
         check_value("page_data_o", 64'(page_data), 64'(exp_page));
         check_value("rs485_di_o", 64'(rs485_di), 64'(r.page_sel[30]));
      end
   endtask

   //-----------------------------------------------------------------------
   // main sequence
   //-----------------------------------------------------------------------
   initial begin
      void'($urandom(32'hbafa));
      err_count     = 0;
      timed_out     = 1'b0;
      exp_loop      = 32'd1;
      exp_page      = 32'd0;
      arst_n        = 1'b0;
      rx_motor_data = '0;
      rx_clken      = 1'b0;
      feedback      = '0;
      page_sel      = '0;
      page_new      = 1'b0;
      pcb_rev       = 4'h9;
      rs485_ro      = 1'b1;
      pfail_n       = '1;
      sw_a_n        = '1;
      sw_b_n        = '1;
      build_table();
      #5;
      wait_edges(16);
      arst_n = 1'b1;
      // all motors parked and readout cleared out of reset
      check_value("pl_clk_o", 64'(pl_clk), 64'hffff);
      check_value("pl_en_o", 64'(pl_en), 64'hffff);
      check_value("pl_dir_o", 64'(pl_dir), 64'hffff);
      check_value("pl_boost_o", 64'(pl_boost), 64'hffff);
      check_value("link_led_n_o", 64'(link_led_n), 64'h1);
      check_value("page_data_o", 64'(page_data), 64'h0);
      foreach (rows[i]) begin
         if (!timed_out) begin
            apply_row(rows[i]);
         end
      end
      $display("errors: %0d, timeouts: %0d", err_count, timed_out);
      if (err_count == 0 && !timed_out) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src/interlock_gate.sv */
//--------------------------------------------------------------------------
// interlock gate: link motor commands pass only while the serial
// feedback word carries the interlock key, else all motors deactivated
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ns

module interlock_gate (
   input  wire                                         gbt_rx_clkrs,
   input  wire                                         arst_n_i,
   input  wire  [mcoi_link_pkg::LINK_MOTOR_W-1:0]      rx_motor_data_i,
   input  wire  mcoi_link_pkg::word_t                  feedback_i,
   input  wire                                         maint_i,
   output logic [mcoi_link_pkg::LINK_MOTOR_W-1:0]      cmd_o,
   output logic                                        link_led_n_o
);

   // loop closed when the feedback echoes the key
   logic key_match;

   assign key_match = (feedback_i == mcoi_link_pkg::INTERLOCK_KEY);

   // all ones sets every deactivate bit, so the drivers stay off
   // until the link is up and the key has come back
   always_ff @(posedge gbt_rx_clkrs or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cmd_o        <= '1;
         link_led_n_o <= 1'b1;
      end else begin
         if (key_match) begin
            cmd_o <= rx_motor_data_i;
         end else begin
            cmd_o <= '1;
         end
         // led on while interlocked, maintenance mode turns it off
         link_led_n_o <= !(key_match && !maint_i);
      end
   end

   //-----------------------------------------------------------------------
   // checks
   //-----------------------------------------------------------------------
   // a broken loop must park all motors on the next edge
   a_mismatch_parks: assert property (
      @(posedge gbt_rx_clkrs) disable iff (!arst_n_i)
      (feedback_i != mcoi_link_pkg::INTERLOCK_KEY) |=> (cmd_o == '1)
   ) else $error("command not parked after interlock mismatch");

endmodule

`default_nettype wire

/* src/mcoi_link_pkg.sv */
//--------------------------------------------------------------------------
// link level definitions: frame and serial word widths, interlock key,
// build identifier and the readout page map
//--------------------------------------------------------------------------

`default_nettype none

package mcoi_link_pkg;

   // motor field of the link frame, 16 motors of 4 bits
   localparam int LINK_MOTOR_W = 64;
   // serial channel word
   localparam int WORD_W = 32;
   // width of the board revision straps
   localparam int PCB_REV_W = 4;

   // the feedback word has to carry this key before commands are used
   localparam logic [WORD_W-1:0] INTERLOCK_KEY = 32'hc0ff_ee42;
   // identifies this firmware build on page 1
   localparam logic [WORD_W-1:0] BUILD_ID = 32'h4d43_0102;
   // returned for any page not in the map
   localparam logic [WORD_W-1:0] POISON_WORD = 32'hdead_beef;

   //-----------------------------------------------------------------------
   // readout pages, selected by the low byte of the page selector
   //-----------------------------------------------------------------------
   localparam logic [7:0] PAGE_LOOPBACK   = 8'd0;
   localparam logic [7:0] PAGE_BUILD      = 8'd1;
   localparam logic [7:0] PAGE_PCBREV     = 8'd2;
   localparam logic [7:0] PAGE_ONE        = 8'd7;
   // first of the sixteen motor status pages
   localparam logic [7:0] PAGE_MOTOR_BASE = 8'd16;
   localparam logic [7:0] PAGE_RS485      = 8'd32;

   // maintenance flag, also echoed in the loopback word
   localparam int MAINT_BIT = 31;
   // drives the rs-485 transmit pin
   localparam int RS485_BIT = 30;

   typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

/* src/mcoi_motor_link.sv */
//--------------------------------------------------------------------------
// motor link core: interlocked command capture, sixteen motor channels
// and the status page readout, all in the recovered link clock
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ns

module mcoi_motor_link (
   input  wire                                          gbt_rx_clkrs,
   input  wire                                          arst_n_i,
   // link frame and serial channel
   input  wire  [mcoi_link_pkg::LINK_MOTOR_W-1:0]       rx_motor_data_i,
   input  wire                                          rx_clken_i,
   input  wire  mcoi_link_pkg::word_t                   feedback_i,
   input  wire  mcoi_link_pkg::word_t                   page_sel_i,
   input  wire                                          page_new_i,
   // board
   input  wire  [mcoi_link_pkg::PCB_REV_W-1:0]          pcb_rev_i,
   input  wire                                          rs485_ro_i,
   // driver feedback, active low
   input  wire  [mcoi_motor_pkg::NUM_MOTORS-1:0]        pfail_n_i,
   input  wire  [mcoi_motor_pkg::NUM_MOTORS-1:0]        sw_a_n_i,
   input  wire  [mcoi_motor_pkg::NUM_MOTORS-1:0]        sw_b_n_i,
   // driver pins
   output logic [mcoi_motor_pkg::NUM_MOTORS-1:0]        pl_clk_o,
   output logic [mcoi_motor_pkg::NUM_MOTORS-1:0]        pl_en_o,
   output logic [mcoi_motor_pkg::NUM_MOTORS-1:0]        pl_dir_o,
   output logic [mcoi_motor_pkg::NUM_MOTORS-1:0]        pl_boost_o,
   output logic [mcoi_link_pkg::LINK_MOTOR_W-1:0]       tx_motor_data_o,
   output mcoi_link_pkg::word_t                         page_data_o,
   output logic                                         rs485_di_o,
   output logic                                         link_led_n_o
);

   // gated commands, 4 bits per motor
   logic [mcoi_link_pkg::LINK_MOTOR_W-1:0] cmd_bus;
   // synchronized statuses, 4 bits per motor
   logic [mcoi_link_pkg::LINK_MOTOR_W-1:0] stat_bus;

   interlock_gate i_interlock_gate (
      .gbt_rx_clkrs    (gbt_rx_clkrs),
      .arst_n_i        (arst_n_i),
      .rx_motor_data_i (rx_motor_data_i),
      .feedback_i      (feedback_i),
      .maint_i         (page_sel_i[mcoi_link_pkg::MAINT_BIT]),
      .cmd_o           (cmd_bus),
      .link_led_n_o    (link_led_n_o)
   );

   //-----------------------------------------------------------------------
   // motor channels, motor n owns slice n of both buses
   //-----------------------------------------------------------------------
   for (genvar n = 0; n < mcoi_motor_pkg::NUM_MOTORS; n++) begin : g_motor
      motor_channel i_motor_channel (
         .gbt_rx_clkrs (gbt_rx_clkrs),
         .arst_n_i     (arst_n_i),
         .cmd_i        (cmd_bus[n*mcoi_motor_pkg::CMD_W +: mcoi_motor_pkg::CMD_W]),
         .pfail_n_i    (pfail_n_i[n]),
         .sw_a_n_i     (sw_a_n_i[n]),
         .sw_b_n_i     (sw_b_n_i[n]),
         .pl_clk_o     (pl_clk_o[n]),
         .pl_en_o      (pl_en_o[n]),
         .pl_dir_o     (pl_dir_o[n]),
         .pl_boost_o   (pl_boost_o[n]),
         .stat_o       (stat_bus[n*mcoi_motor_pkg::STAT_W +: mcoi_motor_pkg::STAT_W])
      );
   end

   status_page_mux i_status_page_mux (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .arst_n_i     (arst_n_i),
      .rx_clken_i   (rx_clken_i),
      .page_sel_i   (page_sel_i),
      .page_new_i   (page_new_i),
      .pcb_rev_i    (pcb_rev_i),
      .rs485_ro_i   (rs485_ro_i),
      .stat_i       (stat_bus),
      .page_data_o  (page_data_o)
   );

   // statuses go back on the link frame as they are
   assign tx_motor_data_o = stat_bus;
   // rs-485 transmit is driven straight from the page selector
   assign rs485_di_o = page_sel_i[mcoi_link_pkg::RS485_BIT];

endmodule

`default_nettype wire

/* src/mcoi_motor_pkg.sv */
//--------------------------------------------------------------------------
// motor definitions for one fibre of the stepper front end
// motor count, command and status field layout, synchronizer depth
//--------------------------------------------------------------------------

`default_nettype none

package mcoi_motor_pkg;

   // motors served by one fibre
   localparam int NUM_MOTORS = 16;

   // bits per motor in the command and status fields of the link frame
   localparam int CMD_W  = 4;
   localparam int STAT_W = 4;

   //-----------------------------------------------------------------------
   // command field positions
   //-----------------------------------------------------------------------
   // step pulse towards the driver clock pin
   localparam int CMD_STEP  = 0;
   // deactivate, high keeps the driver disabled
   localparam int CMD_DEACT = 1;
   // direction
   localparam int CMD_DIR   = 2;
   // current boost
   localparam int CMD_BOOST = 3;

   //-----------------------------------------------------------------------
   // status field positions
   //-----------------------------------------------------------------------
   // driver fail, inverted from the pin
   localparam int ST_FAIL = 0;
   // end switches a and b, inverted from the pins
   localparam int ST_SW_A = 1;
   localparam int ST_SW_B = 2;
   // overheat, no sensor wired so always zero
   localparam int ST_OH   = 3;

   // flops between the driver pins and the link clock domain
   localparam int SYNC_STAGES = 3;

   // one motor command and one motor status
   typedef logic [CMD_W-1:0]  motor_cmd_t;
   typedef logic [STAT_W-1:0] motor_stat_t;

endpackage

`default_nettype wire

/* src/motor_channel.sv */
//--------------------------------------------------------------------------
// one motor channel: command fields onto the driver pins, inverted
// driver fault and end switches through a synchronizer into a status
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ns

module motor_channel (
   input  wire                                gbt_rx_clkrs,
   input  wire                                arst_n_i,
   input  wire  mcoi_motor_pkg::motor_cmd_t   cmd_i,
   input  wire                                pfail_n_i,
   input  wire                                sw_a_n_i,
   input  wire                                sw_b_n_i,
   output logic                               pl_clk_o,
   output logic                               pl_en_o,
   output logic                               pl_dir_o,
   output logic                               pl_boost_o,
   output mcoi_motor_pkg::motor_stat_t        stat_o
);

   // status as seen on the pins, still asynchronous
   mcoi_motor_pkg::motor_stat_t stat_raw;
   // synchronizer chain, stage 0 is the metastable one
   mcoi_motor_pkg::motor_stat_t sync_q [mcoi_motor_pkg::SYNC_STAGES];

   //-----------------------------------------------------------------------
   // driver pins
   //-----------------------------------------------------------------------
   // straight mapping, the command is already registered in the gate
   assign pl_clk_o   = cmd_i[mcoi_motor_pkg::CMD_STEP];
   assign pl_en_o    = cmd_i[mcoi_motor_pkg::CMD_DEACT];
   assign pl_dir_o   = cmd_i[mcoi_motor_pkg::CMD_DIR];
   assign pl_boost_o = cmd_i[mcoi_motor_pkg::CMD_BOOST];

   //-----------------------------------------------------------------------
   // status capture
   //-----------------------------------------------------------------------
   always_comb begin
      stat_raw = '0;
      // pins are active low, status bits active high
      stat_raw[mcoi_motor_pkg::ST_FAIL] = !pfail_n_i;
      stat_raw[mcoi_motor_pkg::ST_SW_A] = !sw_a_n_i;
      stat_raw[mcoi_motor_pkg::ST_SW_B] = !sw_b_n_i;
      // no overheat sensor on this board
      stat_raw[mcoi_motor_pkg::ST_OH]   = 1'b0;
   end

   always_ff @(posedge gbt_rx_clkrs or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < mcoi_motor_pkg::SYNC_STAGES; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         sync_q[0] <= stat_raw;
         // shift along the chain
         for (int i = 1; i < mcoi_motor_pkg::SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // last stage is safe to use in the link domain
   assign stat_o = sync_q[mcoi_motor_pkg::SYNC_STAGES-1];

   //-----------------------------------------------------------------------
   // checks
   //-----------------------------------------------------------------------
   // overheat is tied off at the pins and must stay zero down the chain
   a_no_overheat: assert property (
      @(posedge gbt_rx_clkrs) disable iff (!arst_n_i)
      stat_o[mcoi_motor_pkg::ST_OH] == 1'b0
   ) else $error("overheat bit set on synchronized status");

endmodule

`default_nettype wire

/* src/status_page_mux.sv */
//--------------------------------------------------------------------------
// readout page multiplexer towards the serial channel, with the
// loopback word reloaded on each new page selector
//--------------------------------------------------------------------------

`default_nettype none
`timescale 1ns/1ns

module status_page_mux (
   input  wire                                       gbt_rx_clkrs,
   input  wire                                       arst_n_i,
   input  wire                                       rx_clken_i,
   input  wire  mcoi_link_pkg::word_t                page_sel_i,
   input  wire                                       page_new_i,
   input  wire  [mcoi_link_pkg::PCB_REV_W-1:0]       pcb_rev_i,
   input  wire                                       rs485_ro_i,
   input  wire  [mcoi_link_pkg::LINK_MOTOR_W-1:0]    stat_i,
   output mcoi_link_pkg::word_t                      page_data_o
);

   // index width of the motor status pages
   localparam int MOTOR_IDX_W = $clog2(mcoi_motor_pkg::NUM_MOTORS);

   mcoi_link_pkg::word_t loopback_q;
   mcoi_link_pkg::word_t page_word;
   logic [7:0]           page;
   // page offset from the first motor page
   logic [7:0]           motor_ofs;
   logic [MOTOR_IDX_W-1:0] motor_idx;

   //-----------------------------------------------------------------------
   // loopback register
   //-----------------------------------------------------------------------
   // echoes the maintenance bit back, bit 0 marks a live register
   always_ff @(posedge gbt_rx_clkrs or negedge arst_n_i) begin
      if (!arst_n_i) begin
         loopback_q <= mcoi_link_pkg::word_t'(1);
      end else if (page_new_i) begin
         loopback_q <= {page_sel_i[mcoi_link_pkg::MAINT_BIT],
                        {(mcoi_link_pkg::WORD_W-2){1'b0}}, 1'b1};
      end
   end

   //-----------------------------------------------------------------------
   // page decode
   //-----------------------------------------------------------------------
   assign page      = page_sel_i[7:0];
   assign motor_ofs = page - mcoi_link_pkg::PAGE_MOTOR_BASE;
   assign motor_idx = motor_ofs[MOTOR_IDX_W-1:0];

   always_comb begin
      case (page)
         mcoi_link_pkg::PAGE_LOOPBACK: page_word = loopback_q;
         mcoi_link_pkg::PAGE_BUILD:    page_word = mcoi_link_pkg::BUILD_ID;
         mcoi_link_pkg::PAGE_PCBREV:   page_word = mcoi_link_pkg::word_t'(pcb_rev_i);
         mcoi_link_pkg::PAGE_ONE:      page_word = mcoi_link_pkg::word_t'(1);
         mcoi_link_pkg::PAGE_RS485:    page_word = mcoi_link_pkg::word_t'(rs485_ro_i);
         default: begin
            // one page per motor, anything else is poisoned
            if (page >= mcoi_link_pkg::PAGE_MOTOR_BASE &&
                motor_ofs < 8'(mcoi_motor_pkg::NUM_MOTORS)) begin
               page_word = mcoi_link_pkg::word_t'(
                  stat_i[motor_idx*mcoi_motor_pkg::STAT_W +: mcoi_motor_pkg::STAT_W]);
            end else begin
               page_word = mcoi_link_pkg::POISON_WORD;
            end
         end
      endcase
   end

   // output only moves on the link clock enable
   always_ff @(posedge gbt_rx_clkrs or negedge arst_n_i) begin
      if (!arst_n_i) begin
         page_data_o <= '0;
      end else if (rx_clken_i) begin
         page_data_o <= page_word;
      end
   end

   //-----------------------------------------------------------------------
   // checks
   //-----------------------------------------------------------------------
   a_hold_without_clken: assert property (
      @(posedge gbt_rx_clkrs) disable iff (!arst_n_i)
      !rx_clken_i |=> $stable(page_data_o)
   ) else $error("page data moved without clock enable");

endmodule

`default_nettype wire
